//--- src/mem_pkg.sv
/*
 * Memory subsystem package
 * Sizes, read pipeline depth, init engine states and the
 * configuration word layout shared by the RAM blocks
 */

package mem_pkg;

    // ----------------------------------------
    // Array geometry
    // ----------------------------------------
    localparam int addr_wid = 6;
    localparam int data_wid = 32;
    localparam int depth    = 2 ** addr_wid;

    // Extra output registers after the array read register
    localparam int rd_pipeline_stages = 1;

    typedef logic [addr_wid-1:0] addr_t;
    typedef logic [data_wid-1:0] data_t;

    // ----------------------------------------
    // Configuration registers
    // ----------------------------------------
    localparam logic cfg_addr_ctrl    = 1'b0;
    localparam logic cfg_addr_pattern = 1'b1;

    // Control word, request bits in the low end
    typedef struct packed {
        logic [data_wid-3:0] reserved;
        logic                soft_rst;
        logic                init_req;
    } cfg_ctrl_t;

    // Same 32-bit word seen as control fields or as a fill pattern
    typedef union packed {
        cfg_ctrl_t ctrl;
        data_t     pattern;
    } cfg_word_u;

    // Init engine states
    localparam logic st_idle = 1'b0;
    localparam logic st_fill = 1'b1;

endpackage : mem_pkg

//--- src/mem_intf.sv
/*
 * Memory port interface
 * Request, address, data, ack, ready and soft reset of one RAM port
 */

`timescale 1ns/1ps

interface mem_intf;
    import mem_pkg::*;

    // Request side
    logic  req;
    addr_t addr;
    data_t data;

    // Response side
    logic  ack;
    logic  rdy;

    // Soft reset toward the RAM port, one cycle pulse
    logic  rst;

    // Write port, controller drives the payload
    // Soft reset comes from the configuration block, not the controller
    modport wr_controller (
        output req, addr, data,
        input  ack, rdy
    );

    modport wr_peripheral (
        input  req, addr, data, rst,
        output ack, rdy
    );

    // Read port, data flows back to the controller
    modport rd_controller (
        output req, addr,
        input  data, ack, rdy
    );

    modport rd_peripheral (
        input  req, addr, rst,
        output data, ack, rdy
    );

endinterface : mem_intf

//--- src/mem_cfg_regs.sv
/*
 * Configuration registers
 * Stores the fill pattern and turns control writes into
 * one-cycle init and soft reset pulses
 */

`timescale 1ns/1ps

module mem_cfg_regs (
    input  logic               rd_clk,
    input  logic               rd_srst_local,
    input  logic               cfg_wr,
    input  logic               cfg_addr,
    input  mem_pkg::cfg_word_u cfg_data,
    output mem_pkg::data_t     fill_pattern,
    output logic               init_start,
    output logic               soft_rst
);
    import mem_pkg::*;

    // Write decode per register
    logic ctrl_wr;
    logic pattern_wr;

    assign ctrl_wr    = cfg_wr && (cfg_addr == cfg_addr_ctrl);
    assign pattern_wr = cfg_wr && (cfg_addr == cfg_addr_pattern);

    // ----------------------------------------
    // Fill pattern register
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (rd_srst_local) begin
            fill_pattern <= '0;
        end else if (pattern_wr) begin
            // Whole word taken as raw pattern
            fill_pattern <= cfg_data.pattern;
        end
    end

    // ----------------------------------------
    // Request pulses
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (rd_srst_local) begin
            init_start <= 1'b0;
            soft_rst   <= 1'b0;
        end else begin
            // Same word read as control fields
            init_start <= ctrl_wr && cfg_data.ctrl.init_req;
            soft_rst   <= ctrl_wr && cfg_data.ctrl.soft_rst;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Downstream blocks expect single-cycle requests
    a_init_start_pulse: assert property (
        @(posedge rd_clk) disable iff (rd_srst_local)
        init_start |=> !init_start
    ) else $error("init_start held for more than one cycle");

    a_soft_rst_pulse: assert property (
        @(posedge rd_clk) disable iff (rd_srst_local)
        soft_rst |=> !soft_rst
    ) else $error("soft_rst held for more than one cycle");

endmodule : mem_cfg_regs

//--- src/mem_reset_fsm.sv
/*
 * Init engine
 * Fills every RAM word with the pattern after reset or on request,
 * otherwise forwards external writes to the RAM write port
 */

`timescale 1ns/1ps

module mem_reset_fsm (
    input  logic           rd_clk,
    input  logic           rd_srst_local,
    input  logic           init_start,
    input  mem_pkg::data_t fill_pattern,
    input  logic           wr_req,
    input  mem_pkg::addr_t wr_addr,
    input  mem_pkg::data_t wr_data,
    mem_intf.wr_controller wr_if,
    output logic           init_done,
    output logic           wr_rdy
);
    import mem_pkg::*;

    logic  state;
    addr_t fill_addr;
    logic  fill_last;

    // Final word of the array
    assign fill_last = (fill_addr == addr_t'(depth - 1));

    // ----------------------------------------
    // State and fill address
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (rd_srst_local) begin
            // Fill starts on its own once reset drops
            state     <= st_fill;
            fill_addr <= '0;
            init_done <= 1'b0;
        end else if (init_start) begin
            // New request restarts from word 0, also mid-fill
            state     <= st_fill;
            fill_addr <= '0;
            init_done <= 1'b0;
        end else if (state == st_fill && wr_if.rdy) begin
            // Advance only on accepted writes, so a soft reset stalls the fill
            fill_addr <= fill_addr + addr_t'(1);
            if (fill_last) begin
                state     <= st_idle;
                init_done <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Write port mux
    // ----------------------------------------
    always_comb begin
        if (state == st_fill) begin
            // Own sequential writes, external side held off
            wr_if.req  = 1'b1;
            wr_if.addr = fill_addr;
            wr_if.data = fill_pattern;
            wr_rdy     = 1'b0;
        end else begin
            wr_if.req  = wr_req;
            wr_if.addr = wr_addr;
            wr_if.data = wr_data;
            wr_rdy     = wr_if.rdy;
        end
    end

    // Status flag kept separately from the state register
    a_no_done_in_fill: assert property (
        @(posedge rd_clk) disable iff (rd_srst_local)
        (state == st_fill) |-> !init_done
    ) else $error("init_done high during fill");

endmodule : mem_reset_fsm

//--- src/mem_ram_sdp_core.sv
/*
 * Simple dual-port RAM core
 * Array with registered write ack, read register plus output
 * pipeline, and per-port soft reset handling
 */

`timescale 1ns/1ps

module mem_ram_sdp_core (
    input  logic           rd_clk,
    input  logic           rd_srst_local,
    mem_intf.wr_peripheral wr_if,
    mem_intf.rd_peripheral rd_if
);
    import mem_pkg::*;

    // Port resets, block reset merged with soft reset
    logic wr_port_rst;
    logic rd_port_rst;

    // Accepted requests
    logic wr_en;
    logic rd_en;

    // Storage
    data_t mem [depth];

    // Read path
    data_t                     rd_word;
    data_t                     rd_out [rd_pipeline_stages];
    logic [rd_pipeline_stages:0] rd_vld;

    // ----------------------------------------
    // Reset combining
    // ----------------------------------------
    // Registered, so a soft reset pulse costs one not-ready cycle
    always_ff @(posedge rd_clk) begin
        wr_port_rst <= rd_srst_local || wr_if.rst;
        rd_port_rst <= rd_srst_local || rd_if.rst;
    end

    // Ready unless the port is in reset
    assign wr_if.rdy = !wr_port_rst;
    assign rd_if.rdy = !rd_port_rst;

    assign wr_en = wr_if.req && wr_if.rdy;
    assign rd_en = rd_if.req && rd_if.rdy;

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (wr_en) begin
            mem[wr_if.addr] <= wr_if.data;
        end
    end

    // Ack in the cycle after acceptance
    always_ff @(posedge rd_clk) begin
        if (wr_port_rst) begin
            wr_if.ack <= 1'b0;
        end else begin
            wr_if.ack <= wr_en;
        end
    end

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    // Array read register, same-edge write gives the old word
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_if.addr];
        end
    end

    // Output registers, each loads when the stage before holds a valid word
    always_ff @(posedge rd_clk) begin
        if (rd_vld[0]) begin
            rd_out[0] <= rd_word;
        end
        for (int i = 1; i < rd_pipeline_stages; i++) begin
            if (rd_vld[i]) begin
                rd_out[i] <= rd_out[i-1];
            end
        end
    end

    // Valid chain, one bit per stage, dropped by port reset
    always_ff @(posedge rd_clk) begin
        if (rd_port_rst) begin
            rd_vld <= '0;
        end else begin
            rd_vld <= {rd_vld[rd_pipeline_stages-1:0], rd_en};
        end
    end

    assign rd_if.data = rd_out[rd_pipeline_stages-1];
    assign rd_if.ack  = rd_vld[rd_pipeline_stages];

    // ----------------------------------------
    // Latency checks
    // ----------------------------------------
    a_wr_ack_latency: assert property (
        @(posedge rd_clk) disable iff (rd_srst_local)
        wr_en |=> wr_if.ack
    ) else $error("wr_ack missing one cycle after accepted write");

    a_wr_ack_source: assert property (
        @(posedge rd_clk) disable iff (rd_srst_local)
        wr_if.ack |-> $past(wr_en)
    ) else $error("wr_ack without accepted write");

    // A soft reset inside the window may drop the read
    a_rd_ack_latency: assert property (
        @(posedge rd_clk) disable iff (rd_srst_local || rd_port_rst)
        rd_en |=> ##rd_pipeline_stages rd_if.ack
    ) else $error("rd_ack missing after accepted read");

    a_rd_ack_source: assert property (
        @(posedge rd_clk) disable iff (rd_srst_local)
        rd_if.ack |-> $past(rd_en, rd_pipeline_stages + 1)
    ) else $error("rd_ack without accepted read");

endmodule : mem_ram_sdp_core

//--- src/mem_ram_top.sv
/*
 * RAM subsystem top level
 * Config registers, init engine and dual-port core on plain ports
 */

`timescale 1ns/1ps

module mem_ram_top (
    input  logic           rd_clk,
    input  logic           rd_srst_local,
    // External write port
    input  logic           wr_req,
    input  mem_pkg::addr_t wr_addr,
    input  mem_pkg::data_t wr_data,
    output logic           wr_rdy,
    output logic           wr_ack,
    // Read port
    input  logic           rd_req,
    input  mem_pkg::addr_t rd_addr,
    output logic           rd_rdy,
    output mem_pkg::data_t rd_data,
    output logic           rd_ack,
    // Configuration writes
    input  logic           cfg_wr,
    input  logic           cfg_addr,
    input  logic [31:0]    cfg_data,
    // Fill status
    output logic           init_done
);

    mem_pkg::data_t fill_pattern;
    logic           init_start;
    logic           soft_rst;

    // Core ports
    mem_intf wr_if ();
    mem_intf rd_if ();

    mem_cfg_regs u_cfg_regs (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .fill_pattern  (fill_pattern),
        .init_start    (init_start),
        .soft_rst      (soft_rst)
    );

    mem_reset_fsm u_reset_fsm (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local),
        .init_start    (init_start),
        .fill_pattern  (fill_pattern),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_if         (wr_if),
        .init_done     (init_done),
        .wr_rdy        (wr_rdy)
    );

    mem_ram_sdp_core u_core (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local),
        .wr_if         (wr_if),
        .rd_if         (rd_if)
    );

    // Soft reset goes to both ports
    assign wr_if.rst = soft_rst;
    assign rd_if.rst = soft_rst;

    // Read port straight onto the interface
    assign rd_if.req  = rd_req;
    assign rd_if.addr = rd_addr;
    assign rd_rdy     = rd_if.rdy;
    assign rd_data    = rd_if.data;
    assign rd_ack     = rd_if.ack;

    // Also pulses for the fill writes of the init engine
    assign wr_ack = wr_if.ack;

endmodule : mem_ram_top

//--- testbench/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 20 ns clock, synchronous reset held for two rising edges
 */

`timescale 1ns/1ps

module tb_clk_gen (
    output logic rd_clk,
    output logic rd_srst_local
);

    // Half period of 10 ns
    initial begin
        rd_clk = 1'b0;
        forever #10 rd_clk = ~rd_clk;
    end

    // Reset drops right after the second rising edge
    initial begin
        rd_srst_local = 1'b1;
        repeat (2) @(posedge rd_clk);
        rd_srst_local <= 1'b0;
    end

endmodule : tb_clk_gen

//--- testbench/tb_mem_ram.sv
/*
 * RAM subsystem testbench
 * Table of writes, reads, config writes and fill waits,
 * checked against a word model of the array
 */

`timescale 1ns/1ps

module tb_mem_ram;
    import mem_pkg::*;

    typedef enum logic [1:0] {op_write, op_read, op_cfg, op_wait_init} op_kind_t;

    // One table row, data is the word count for reads
    // exp_rdy holds the expected rd_rdy and wr_rdy at write issue
    typedef struct packed {
        int         test;
        op_kind_t   kind;
        addr_t      addr;
        data_t      data;
        logic [1:0] exp_rdy;
    } op_t;

    logic  rd_clk;
    logic  rd_srst_local;
    logic  wr_req;
    addr_t wr_addr;
    data_t wr_data;
    logic  wr_rdy;
    logic  wr_ack;
    logic  rd_req;
    addr_t rd_addr;
    logic  rd_rdy;
    data_t rd_data;
    logic  rd_ack;
    logic  cfg_wr;
    logic  cfg_addr;
    data_t cfg_data;
    logic  init_done;

    op_t   ops [$];
    data_t model [depth];
    data_t fill_value;
    int    pass_cnt;
    int    fail_cnt;
    int    cycle_cnt;
    int    cycle_limit;
    int    cur_test;
    int    test_base;

    tb_clk_gen u_clk_gen (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local)
    );

    mem_ram_top u_dut (
        .rd_clk        (rd_clk),
        .rd_srst_local (rd_srst_local),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_rdy        (wr_rdy),
        .wr_ack        (wr_ack),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .rd_data       (rd_data),
        .rd_ack        (rd_ack),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .init_done     (init_done)
    );

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr_ack(input logic got, input logic exp, input string what);
        if (got === exp) begin
            pass_cnt++;
        end else if (exp) begin
            fail_cnt++;
            $display("At %0t the %s did not arrive when it was due", $time, what);
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s high with no request due", $time, what);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ----------------------------------------
    // Bus operations
    // ----------------------------------------
    // Single write, request held for one edge, then two cycles of ack checks
    task automatic write_word(input addr_t addr, input data_t data, input logic [1:0] exp_rdy);
        logic accepted;
        logic idle;
        @(posedge rd_clk);
        wr_req  <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(negedge rd_clk);
        check_flag(wr_rdy, exp_rdy[0], "wr_rdy at write issue");
        check_flag(rd_rdy, exp_rdy[1], "rd_rdy at write issue");
        accepted = exp_rdy[0];
        // Fill writes also pulse wr_ack, so ack is only checked outside a fill
        idle     = init_done;
        @(posedge rd_clk);
        wr_req <= 1'b0;
        @(negedge rd_clk);
        if (accepted || idle)
            check_addr_ack(wr_ack, accepted, "wr_ack");
        @(posedge rd_clk);
        @(negedge rd_clk);
        if (idle)
            check_addr_ack(wr_ack, 1'b0, "wr_ack one cycle later");
        if (accepted)
            model[addr] = data;
    endtask

    // Back-to-back reads from base upward, ack due two edges after acceptance
    task automatic read_words(input addr_t base, input int count);
        addr_t a;
        for (int j = 0; j < count + 3; j++) begin
            @(posedge rd_clk);
            rd_req  <= (j < count);
            rd_addr <= base + addr_t'(j);
            @(negedge rd_clk);
            if (j < count)
                check_flag(rd_rdy, 1'b1, "rd_rdy at read issue");
            if (j >= 2 && j < count + 2) begin
                a = base + addr_t'(j - 2);
                check_addr_ack(rd_ack, 1'b1, "rd_ack");
                check_data(rd_data, model[a], $sformatf("rd_data at address %0d", a));
            end else begin
                check_addr_ack(rd_ack, 1'b0, "rd_ack");
            end
        end
    endtask

    task automatic write_cfg(input logic addr, input data_t data);
        @(posedge rd_clk);
        cfg_wr   <= 1'b1;
        cfg_addr <= addr;
        cfg_data <= data;
        @(posedge rd_clk);
        cfg_wr <= 1'b0;
        @(negedge rd_clk);
        if (addr == cfg_addr_pattern)
            fill_value = data;
    endtask

    // Fill must be running on entry, then the whole array holds the pattern
    task automatic wait_for_init();
        @(negedge rd_clk);
        check_flag(init_done, 1'b0, "init_done during fill");
        check_flag(wr_rdy, 1'b0, "wr_rdy during fill");
        while (init_done !== 1'b1)
            @(negedge rd_clk);
        check_flag(wr_rdy, 1'b1, "wr_rdy after fill");
        for (int i = 0; i < depth; i++)
            model[i] = fill_value;
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    function automatic data_t ctrl_word(input logic init_req, input logic soft_rst);
        cfg_word_u w;
        w.ctrl.reserved = '0;
        w.ctrl.soft_rst = soft_rst;
        w.ctrl.init_req = init_req;
        return w.pattern;
    endfunction

    function automatic void add_op(input int test, input op_kind_t kind, input int addr,
                                   input data_t data, input logic [1:0] exp_rdy);
        op_t op;
        op.test    = test;
        op.kind    = kind;
        op.addr    = addr_t'(addr);
        op.data    = data;
        op.exp_rdy = exp_rdy;
        ops.push_back(op);
    endfunction

    task automatic build_table();
        int cost;
        // Reset fill to zero, full readback
        add_op(1, op_wait_init, 0, '0, 2'b11);
        add_op(1, op_read, 0, depth, 2'b11);
        // Plain writes, then reads in bursts, one wrapping past the top
        add_op(2, op_write, 5, 32'h1234_5678, 2'b11);
        add_op(2, op_write, 6, 32'hdead_beef, 2'b11);
        add_op(2, op_write, 63, 32'ha5a5_5a5a, 2'b11);
        add_op(2, op_write, 0, 32'h0000_0001, 2'b11);
        add_op(2, op_read, 5, 2, 2'b11);
        add_op(2, op_read, 62, 3, 2'b11);
        add_op(2, op_read, 4, 1, 2'b11);
        // Programmed pattern and requested fill
        add_op(3, op_cfg, int'(cfg_addr_pattern), 32'hc3c3_3c3c, 2'b11);
        add_op(3, op_cfg, int'(cfg_addr_ctrl), ctrl_word(1'b1, 1'b0), 2'b11);
        add_op(3, op_wait_init, 0, '0, 2'b11);
        add_op(3, op_read, 0, depth, 2'b11);
        // Write during a fill is dropped
        // Word 0 is filled while the request is up, so nothing rewrites it later
        add_op(4, op_cfg, int'(cfg_addr_pattern), 32'h0f0f_f0f0, 2'b11);
        add_op(4, op_cfg, int'(cfg_addr_ctrl), ctrl_word(1'b1, 1'b0), 2'b11);
        add_op(4, op_write, 0, 32'h1111_1111, 2'b10);
        add_op(4, op_wait_init, 0, '0, 2'b11);
        add_op(4, op_read, 0, 1, 2'b11);
        // Soft reset, one not-ready cycle on both ports
        add_op(5, op_write, 20, 32'h5555_aaaa, 2'b11);
        add_op(5, op_cfg, int'(cfg_addr_ctrl), ctrl_word(1'b0, 1'b1), 2'b11);
        add_op(5, op_write, 21, 32'h7777_7777, 2'b00);
        add_op(5, op_write, 22, 32'h2222_2222, 2'b11);
        add_op(5, op_read, 0, depth, 2'b11);
        // Random mix of single writes and reads
        for (int i = 0; i < 40; i++) begin
            if ($urandom_range(1, 0) == 1)
                add_op(6, op_write, $urandom_range(depth - 1, 0), $urandom, 2'b11);
            else
                add_op(6, op_read, $urandom_range(depth - 1, 0), 1, 2'b11);
        end
        // Cycles per row, plus three fills and some slack
        cost = 0;
        foreach (ops[i])
            cost += (ops[i].kind == op_read) ? int'(ops[i].data) + 4 : 4;
        cycle_limit = cost + 3 * (depth + 1) + 20;
    endtask

    // ----------------------------------------
    // Timeout
    // ----------------------------------------
    always @(posedge rd_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout, run went past %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(28303));
        wr_req      = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        rd_req      = 1'b0;
        rd_addr     = '0;
        cfg_wr      = 1'b0;
        cfg_addr    = 1'b0;
        cfg_data    = '0;
        fill_value  = '0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cycle_cnt   = 0;
        cycle_limit = 1000;
        build_table();
        wait (rd_srst_local === 1'b0);
        cur_test  = ops[0].test;
        test_base = fail_cnt;
        foreach (ops[i]) begin
            // Line per test once its last row is done
            if (ops[i].test != cur_test) begin
                $display("Test %0d finished, %0d errors", cur_test, fail_cnt - test_base);
                cur_test  = ops[i].test;
                test_base = fail_cnt;
            end
            case (ops[i].kind)
                op_write: write_word(ops[i].addr, ops[i].data, ops[i].exp_rdy);
                op_read:  read_words(ops[i].addr, int'(ops[i].data));
                op_cfg:   write_cfg(ops[i].addr[0], ops[i].data);
                default:  wait_for_init();
            endcase
        end
        $display("Test %0d finished, %0d errors", cur_test, fail_cnt - test_base);
        $display("Checks run: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule : tb_mem_ram

//--- build.f
src/mem_pkg.sv
src/mem_intf.sv
src/mem_cfg_regs.sv
src/mem_reset_fsm.sv
src/mem_ram_sdp_core.sv
src/mem_ram_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mem_ram.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RAM subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mem_ram -f build.f

# A nonzero exit of the simulation also stops the script here
out=$(./obj_dir/Vtb_mem_ram)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
